//--- all.f
hdl/cgra_pkg.sv
hdl/cgra_ctrl_if.sv
hdl/cgra_load_if.sv
hdl/cgra_csr.sv
hdl/cgra_config_loader.sv
hdl/cgra_exec_ctrl.sv
hdl/cgra_top.sv
verif/cgra_asserts.sv
verif/tb_cgra_top.sv

//--- hdl/cgra_config_loader.sv
`timescale 1ns/10ps
`default_nettype none

module cgra_config_loader (
    input  logic                              clk,
    input  logic                              rst_n,
    cgra_load_if.loader                       load,
    output logic [cgra_pkg::CFG_ADDR_W-1:0]   cfg_mem_addr,
    output logic                              cfg_mem_read,
    input  logic [cgra_pkg::CONFIG_WIDTH-1:0] cfg_mem_rdata,
    input  logic                              cfg_mem_valid
);

    import cgra_pkg::*;

    logic                    fetching;
    logic                    holding;
    logic                    active_buffer;
    logic                    size_bad;
    logic [FRAME_IDX_W-1:0]  frame_idx;
    logic [FRAME_IDX_W-1:0]  frame_last;
    logic [NUM_PES-1:0]      frame_written;
    logic [CONFIG_WIDTH-1:0] frame_mem [2][NUM_PES];

    assign size_bad = (load.bitstream_size == '0) ||
                      (load.bitstream_size > BS_SIZE_W'(NUM_PES));

    // =========================================================================
    // Fetch sequencer, one outstanding read at a time
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetching        <= 1'b0;
            holding         <= 1'b0;
            frame_idx       <= '0;
            frame_last      <= '0;
            frame_written   <= '0;
            cfg_mem_addr    <= '0;
            cfg_mem_read    <= 1'b0;
            load.load_done  <= 1'b0;
            load.load_error <= 1'b0;
        end else begin
            cfg_mem_read    <= 1'b0;
            load.load_done  <= 1'b0;
            load.load_error <= 1'b0;
            if (holding) begin
                // Back to idle once the request is withdrawn
                if (!load.load_start) begin
                    holding <= 1'b0;
                end
            end else if (fetching) begin
                if (cfg_mem_valid) begin
                    frame_written[frame_idx] <= 1'b1;
                    if (frame_idx == frame_last) begin
                        fetching       <= 1'b0;
                        holding        <= 1'b1;
                        load.load_done <= 1'b1;
                    end else begin
                        frame_idx    <= frame_idx + 1'b1;
                        cfg_mem_addr <= cfg_mem_addr + CFG_ADDR_W'(FRAME_BYTES);
                        cfg_mem_read <= 1'b1;
                    end
                end
            end else if (load.load_start) begin
                if (size_bad) begin
                    load.load_error <= 1'b1;
                    holding         <= 1'b1;
                end else begin
                    fetching      <= 1'b1;
                    frame_idx     <= '0;
                    frame_last    <= FRAME_IDX_W'(load.bitstream_size - 1'b1);
                    frame_written <= '0;
                    cfg_mem_addr  <= load.bitstream_addr;
                    cfg_mem_read  <= 1'b1;
                end
            end
        end
    end

    // Fill the shadow bank; on swap, frames skipped by the load inherit the active copy
    always_ff @(posedge clk) begin
        if (fetching && cfg_mem_valid) begin
            frame_mem[~active_buffer][frame_idx] <= cfg_mem_rdata;
        end else if (load.swap) begin
            for (int i = 0; i < NUM_PES; i++) begin
                if (!frame_written[i]) begin
                    frame_mem[~active_buffer][i] <= frame_mem[active_buffer][i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_buffer     <= 1'b0;
            load.config_valid <= 1'b0;
        end else if (load.swap) begin
            active_buffer     <= ~active_buffer;
            load.config_valid <= 1'b1;
        end
    end

    // Readback of the active bank only, nothing before the first swap
    assign load.frame_data = load.config_valid ? frame_mem[active_buffer][load.frame_sel] : '0;

endmodule

`default_nettype wire

//--- hdl/cgra_csr.sv
`timescale 1ns/10ps
`default_nettype none

module cgra_csr (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            csr_wr,
    input  logic                            csr_rd,
    input  logic [cgra_pkg::CSR_ADDR_W-1:0] csr_addr,
    input  logic [cgra_pkg::CSR_DATA_W-1:0] csr_wdata,
    output logic [cgra_pkg::CSR_DATA_W-1:0] csr_rdata,
    output logic                            csr_rvalid,
    cgra_ctrl_if.csr                        ctrl,
    cgra_load_if.csr                        load
);

    import cgra_pkg::*;

    logic                  win_hit;
    logic [CSR_DATA_W-1:0] rd_word;

    // Upper half of the map is the frame window, two words per frame
    assign win_hit        = (csr_addr >= FRAME_WIN_BASE);
    assign load.frame_sel = csr_addr[FRAME_IDX_W+2:3];

    // =========================================================================
    // Register writes
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl.cgra_start     <= 1'b0;
            ctrl.cfg_start      <= 1'b0;
            ctrl.cgra_reset     <= 1'b0;
            ctrl.irq_mask       <= '0;
            load.bitstream_addr <= '0;
            load.bitstream_size <= '0;
        end else begin
            // Soft reset is a single-cycle strobe
            ctrl.cgra_reset <= csr_wr && (csr_addr == REG_CTRL) && csr_wdata[CTRL_SOFT_RST];
            if (csr_wr) begin
                case (csr_addr)
                    REG_CTRL: begin
                        ctrl.cgra_start <= csr_wdata[CTRL_START];
                        ctrl.cfg_start  <= csr_wdata[CTRL_CFG_START];
                    end
                    REG_BS_ADDR:  load.bitstream_addr <= csr_wdata[CFG_ADDR_W-1:0];
                    REG_BS_SIZE:  load.bitstream_size <= csr_wdata[BS_SIZE_W-1:0];
                    REG_IRQ_MASK: ctrl.irq_mask <= csr_wdata[IRQ_ERR:IRQ_DONE];
                    default: ;
                endcase
            end
        end
    end

    // =========================================================================
    // Read mux
    // =========================================================================
    always_comb begin
        rd_word = '0;
        if (win_hit) begin
            // Word bit 2 picks the high half of the frame
            rd_word = csr_addr[2] ? load.frame_data[CONFIG_WIDTH-1:CSR_DATA_W]
                                  : load.frame_data[CSR_DATA_W-1:0];
        end else begin
            case (csr_addr)
                REG_CTRL:        rd_word = CSR_DATA_W'({ctrl.cfg_start, ctrl.cgra_start});
                REG_STATUS:      rd_word = CSR_DATA_W'({load.config_valid, ctrl.error, ctrl.busy});
                REG_BS_ADDR:     rd_word = CSR_DATA_W'(load.bitstream_addr);
                REG_BS_SIZE:     rd_word = CSR_DATA_W'(load.bitstream_size);
                REG_IRQ_MASK:    rd_word = CSR_DATA_W'(ctrl.irq_mask);
                REG_PERF_CYCLES: rd_word = ctrl.perf_cycles;
                default:         rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_rvalid <= 1'b0;
        end else begin
            csr_rvalid <= csr_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_rd) begin
            csr_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cgra_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface cgra_ctrl_if;

    import cgra_pkg::*;

    // Control from the register block
    logic                  cgra_start;
    logic                  cfg_start;
    logic                  cgra_reset;
    logic [1:0]            irq_mask;

    // Status back from execution control
    logic                  busy;
    logic                  error;
    logic [CSR_DATA_W-1:0] perf_cycles;

    modport csr (
        output cgra_start, cfg_start, cgra_reset, irq_mask,
        input  busy, error, perf_cycles
    );

    modport exec (
        input  cgra_start, cfg_start, cgra_reset, irq_mask,
        output busy, error, perf_cycles
    );

endinterface

`default_nettype wire

//--- hdl/cgra_exec_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cgra_exec_ctrl (
    input  logic      clk,
    input  logic      rst_n,
    cgra_ctrl_if.exec ctrl,
    cgra_load_if.exec load,
    output logic      irq
);

    import cgra_pkg::*;

    exec_state_t state;
    exec_state_t state_next;

    // =========================================================================
    // Execution FSM
    // =========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.cgra_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:     if (ctrl.cgra_start && ctrl.cfg_start) state_next = WAIT_CFG;
            WAIT_CFG: begin
                if (load.load_done) begin
                    state_next = SETUP;
                end else if (load.load_error) begin
                    state_next = ERROR;
                end
            end
            SETUP:    state_next = RUN;
            RUN:      if (!ctrl.cgra_start) state_next = DRAIN;
            DRAIN:    state_next = COMPLETE;
            COMPLETE: state_next = IDLE;
            ERROR:    if (!ctrl.cgra_start) state_next = IDLE;
            default:  state_next = IDLE;
        endcase
    end

    // Load request level and swap strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load.load_start <= 1'b0;
            load.swap       <= 1'b0;
        end else begin
            if (load.load_done || load.load_error) begin
                load.load_start <= 1'b0;
            end else if (ctrl.cfg_start && (state == IDLE)) begin
                load.load_start <= 1'b1;
            end
            load.swap <= load.load_done && (state == WAIT_CFG);
        end
    end

    // Run cycle counter
    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.cgra_reset) begin
            ctrl.perf_cycles <= '0;
        end else if (state == RUN) begin
            ctrl.perf_cycles <= ctrl.perf_cycles + 1'b1;
        end
    end

    assign ctrl.busy  = (state != IDLE) && (state != COMPLETE);
    assign ctrl.error = (state == ERROR) || load.load_error;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= (ctrl.irq_mask[IRQ_DONE] && (state == COMPLETE)) ||
                   (ctrl.irq_mask[IRQ_ERR] && ctrl.error);
        end
    end

endmodule

`default_nettype wire

//--- hdl/cgra_load_if.sv
`timescale 1ns/10ps
`default_nettype none

interface cgra_load_if;

    import cgra_pkg::*;

    logic                    load_start;
    logic                    swap;
    logic                    load_done;
    logic                    load_error;
    logic                    config_valid;
    logic [CFG_ADDR_W-1:0]   bitstream_addr;
    logic [BS_SIZE_W-1:0]    bitstream_size;
    logic [FRAME_IDX_W-1:0]  frame_sel;
    logic [CONFIG_WIDTH-1:0] frame_data;

    modport csr (output bitstream_addr, bitstream_size, frame_sel,
                 input  frame_data, config_valid);
    modport exec (output load_start, swap, input load_done, load_error);
    modport loader (input  load_start, swap, bitstream_addr, bitstream_size, frame_sel,
                    output frame_data, load_done, load_error, config_valid);

endinterface

`default_nettype wire

//--- hdl/cgra_pkg.sv
`default_nettype none

package cgra_pkg;

    // Array geometry and frame format
    localparam int NUM_PES      = 16;
    localparam int CONFIG_WIDTH = 64;
    localparam int FRAME_BYTES  = 8;
    localparam int FRAME_IDX_W  = 4;

    // Port widths
    localparam int CFG_ADDR_W = 32;
    localparam int BS_SIZE_W  = 16;
    localparam int CSR_ADDR_W = 8;
    localparam int CSR_DATA_W = 32;

    // Register map, byte offsets
    localparam logic [CSR_ADDR_W-1:0] REG_CTRL        = 8'h00;
    localparam logic [CSR_ADDR_W-1:0] REG_STATUS      = 8'h04;
    localparam logic [CSR_ADDR_W-1:0] REG_BS_ADDR     = 8'h08;
    localparam logic [CSR_ADDR_W-1:0] REG_BS_SIZE     = 8'h0C;
    localparam logic [CSR_ADDR_W-1:0] REG_IRQ_MASK    = 8'h10;
    localparam logic [CSR_ADDR_W-1:0] REG_PERF_CYCLES = 8'h14;
    localparam logic [CSR_ADDR_W-1:0] FRAME_WIN_BASE  = 8'h80;

    // CTRL and IRQ_MASK bit positions
    localparam int CTRL_START     = 0;
    localparam int CTRL_CFG_START = 1;
    localparam int CTRL_SOFT_RST  = 2;
    localparam int IRQ_DONE       = 0;
    localparam int IRQ_ERR        = 1;

    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        WAIT_CFG = 3'd1,
        SETUP    = 3'd2,
        RUN      = 3'd3,
        DRAIN    = 3'd4,
        COMPLETE = 3'd5,
        ERROR    = 3'd6
    } exec_state_t;

endpackage

`default_nettype wire

//--- hdl/cgra_top.sv
`timescale 1ns/10ps
`default_nettype none

module cgra_top (
    input  logic                              clk,
    input  logic                              rst_n,

    // Register port
    input  logic                              csr_wr,
    input  logic                              csr_rd,
    input  logic [cgra_pkg::CSR_ADDR_W-1:0]   csr_addr,
    input  logic [cgra_pkg::CSR_DATA_W-1:0]   csr_wdata,
    output logic [cgra_pkg::CSR_DATA_W-1:0]   csr_rdata,
    output logic                              csr_rvalid,

    // Configuration memory
    output logic [cgra_pkg::CFG_ADDR_W-1:0]   cfg_mem_addr,
    output logic                              cfg_mem_read,
    input  logic [cgra_pkg::CONFIG_WIDTH-1:0] cfg_mem_rdata,
    input  logic                              cfg_mem_valid,

    output logic                              irq
);

    cgra_ctrl_if ctrl_bus ();
    cgra_load_if load_bus ();

    cgra_csr u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_wr     (csr_wr),
        .csr_rd     (csr_rd),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .csr_rvalid (csr_rvalid),
        .ctrl       (ctrl_bus.csr),
        .load       (load_bus.csr)
    );

    cgra_config_loader u_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .load          (load_bus.loader),
        .cfg_mem_addr  (cfg_mem_addr),
        .cfg_mem_read  (cfg_mem_read),
        .cfg_mem_rdata (cfg_mem_rdata),
        .cfg_mem_valid (cfg_mem_valid)
    );

    cgra_exec_ctrl u_exec (.clk(clk), .rst_n(rst_n), .ctrl(ctrl_bus.exec),
                           .load(load_bus.exec), .irq(irq));

endmodule

`default_nettype wire

//--- verif/cgra_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module cgra_asserts (
    input logic clk,
    input logic rst_n,
    input logic csr_rd,
    input logic csr_rvalid,
    input logic cfg_mem_read,
    input logic cfg_mem_valid,
    input logic irq
);

    logic fetch_pending;

    // Tracks the single outstanding configuration fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pending <= 1'b0;
        end else if (cfg_mem_read) begin
            fetch_pending <= 1'b1;
        end else if (cfg_mem_valid) begin
            fetch_pending <= 1'b0;
        end
    end

    read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_mem_read |=> !cfg_mem_read)
        else $error("cfg_mem_read held high for more than one cycle");

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_mem_read |-> !fetch_pending)
        else $error("cfg_mem_read issued before cfg_mem_valid ended the last fetch");

    rvalid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        csr_rvalid == $past(csr_rd))
        else $error("csr_rvalid does not follow csr_rd by one cycle");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!irq && !cfg_mem_read))
        else $error("irq or cfg_mem_read high in the first cycle after reset");

endmodule

bind cgra_top cgra_asserts asserts0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .csr_rd        (csr_rd),
    .csr_rvalid    (csr_rvalid),
    .cfg_mem_read  (cfg_mem_read),
    .cfg_mem_valid (cfg_mem_valid),
    .irq           (irq)
);

`default_nettype wire

//--- verif/tb_cgra_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cgra_top;

    import cgra_pkg::*;

    localparam int          TIMEOUT  = 200;
    localparam int          NO_STALL = 1000000;
    localparam logic [31:0] BASE1    = 32'h0000_1000;
    localparam logic [31:0] BASE2    = 32'h0000_2400;

    logic        clk;
    logic        rst_n;
    logic        csr_wr;
    logic        csr_rd;
    logic [7:0]  csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic        csr_rvalid;
    logic [31:0] cfg_mem_addr;
    logic        cfg_mem_read;
    logic [63:0] cfg_mem_rdata;
    logic        cfg_mem_valid;
    logic        irq;
    logic [63:0] exp_frame [NUM_PES];
    int          served      = 0;
    int          stall_limit = NO_STALL;
    int          mem_reads   = 0;

    cgra_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================================================
    // Reference model and helpers
    // ========================================================================
    function automatic logic [63:0] frame_word(input logic [31:0] addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = (addr * 32'h9e37_79b1) ^ 32'h5a5a_1234;
        hi = {addr[15:0], addr[31:16]} ^ (addr + 32'h0bad_c0de);
        return {hi, lo};
    endfunction

    task automatic step;
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run;
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        abort_run();
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        csr_wr    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        step();
        csr_wr    = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        int n;
        n        = 0;
        csr_rd   = 1'b1;
        csr_addr = addr;
        step();
        csr_rd   = 1'b0;
        while (!csr_rvalid && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!csr_rvalid) begin
            timeout_fail("csr_rvalid");
        end
        data = csr_rdata;
    endtask

    task automatic poll_reg(input logic [7:0] addr, input logic [31:0] mask,
                            input logic [31:0] value, input string what);
        int          n;
        logic [31:0] d;
        n = 0;
        read_reg(addr, d);
        while (((d & mask) !== value) && n < TIMEOUT) begin
            read_reg(addr, d);
            n++;
        end
        if ((d & mask) !== value) begin
            timeout_fail(what);
        end
    endtask

    task automatic wait_irq(input string what);
        int n;
        n = 0;
        while (!irq && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!irq) begin
            timeout_fail(what);
        end
    endtask

    task automatic wait_served(input int count);
        int n;
        n = 0;
        while (served < count && n < TIMEOUT) begin
            step();
            n++;
        end
        if (served < count) begin
            timeout_fail("configuration memory responses");
        end
    endtask

    // Frame i sits at window words 2i and 2i+1
    task automatic check_window;
        logic [31:0] d;
        for (int i = 0; i < NUM_PES; i++) begin
            read_reg(FRAME_WIN_BASE + 8'(8 * i), d);
            check_eq($sformatf("frame %0d low", i), d, exp_frame[i][31:0]);
            read_reg(FRAME_WIN_BASE + 8'(8 * i + 4), d);
            check_eq($sformatf("frame %0d high", i), d, exp_frame[i][63:32]);
        end
    endtask

    // ========================================================================
    // Configuration memory model
    // ========================================================================
    always @(posedge clk) begin
        if (cfg_mem_read) begin
            mem_reads <= mem_reads + 1;
        end
    end

    initial begin
        logic [31:0] addr;
        int          n;
        cfg_mem_valid = 1'b0;
        cfg_mem_rdata = '0;
        step();
        forever begin
            if (cfg_mem_read) begin
                addr = cfg_mem_addr;
                n    = 0;
                // Held back while the stimulus inspects a partial load
                while (served >= stall_limit && n < TIMEOUT) begin
                    step();
                    n++;
                end
                if (served >= stall_limit) begin
                    timeout_fail("the memory stall to be released");
                end
                repeat ($urandom_range(1, 5)) step();
                cfg_mem_valid = 1'b1;
                cfg_mem_rdata = frame_word(addr);
                served++;
                step();
                cfg_mem_valid = 1'b0;
            end else begin
                step();
            end
        end
    end

    // Watchdog
    initial begin
        repeat (20000) @(posedge clk);
        $display("Simulation ran past its cycle limit");
        abort_run();
    end

    // ========================================================================
    // Stimulus and checks
    // ========================================================================
    initial begin
        logic [31:0] d;
        logic [31:0] perf_a;
        int          reads_before;
        void'($urandom(32'h58bf));
        rst_n     = 1'b0;
        csr_wr    = 1'b0;
        csr_rd    = 1'b0;
        csr_addr  = '0;
        csr_wdata = '0;
        for (int i = 0; i < NUM_PES; i++) begin
            exp_frame[i] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step();

        // Reset state
        check_eq("irq", irq, 1'b0);
        read_reg(REG_STATUS, d);
        check_eq("status", d, 32'h0);
        read_reg(REG_PERF_CYCLES, d);
        check_eq("perf_cycles", d, 32'h0);
        check_window();

        // Full load with the done interrupt
        write_reg(REG_BS_ADDR, BASE1);
        write_reg(REG_BS_SIZE, 32'd16);
        write_reg(REG_IRQ_MASK, 32'h1);
        write_reg(REG_CTRL, 32'h3);
        for (int i = 0; i < NUM_PES; i++) begin
            exp_frame[i] = frame_word(BASE1 + 32'(8 * i));
        end
        poll_reg(REG_STATUS, 32'h4, 32'h4, "config_valid");
        check_window();
        write_reg(REG_CTRL, 32'h0);
        wait_irq("the done interrupt");
        read_reg(REG_STATUS, d);
        check_eq("status busy", d[0], 1'b0);

        // Partial reload into the shadow bank
        write_reg(REG_BS_ADDR, BASE2);
        write_reg(REG_BS_SIZE, 32'd5);
        stall_limit = served + 3;
        write_reg(REG_CTRL, 32'h3);
        wait_served(stall_limit);
        check_window();
        stall_limit = NO_STALL;
        for (int i = 0; i < 5; i++) begin
            exp_frame[i] = frame_word(BASE2 + 32'(8 * i));
        end
        poll_reg(FRAME_WIN_BASE, 32'hffff_ffff, exp_frame[0][31:0], "the buffer swap");
        read_reg(REG_STATUS, d);
        check_eq("status", d, 32'h5);
        check_window();

        // Run cycle counter over reads issued seven cycles apart
        read_reg(REG_PERF_CYCLES, perf_a);
        repeat (6) step();
        read_reg(REG_PERF_CYCLES, d);
        check_eq("perf_cycles delta", d - perf_a, 32'd7);

        // Soft reset in RUN while start stays set
        write_reg(REG_CTRL, 32'h5);
        poll_reg(REG_STATUS, 32'h1, 32'h0, "busy to clear after soft reset");
        read_reg(REG_PERF_CYCLES, d);
        check_eq("perf_cycles", d, 32'h0);
        check_window();

        // Zero-size bitstream with the error interrupt
        reads_before = mem_reads;
        write_reg(REG_BS_SIZE, 32'd0);
        write_reg(REG_IRQ_MASK, 32'h2);
        write_reg(REG_CTRL, 32'h3);
        wait_irq("the error interrupt");
        read_reg(REG_STATUS, d);
        check_eq("status error", d[1], 1'b1);
        check_eq("cfg_mem_read count", mem_reads, reads_before);
        write_reg(REG_CTRL, 32'h0);
        poll_reg(REG_STATUS, 32'h1, 32'h0, "busy to clear after error");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
